// ==== include/occ_track_defs.svh ====
// Occupancy tracker sizing constants
// Shared widths and limits for the event decoder, the counter and the
// watermark stage of the occupancy tracking pipeline

`ifndef OCC_TRACK_DEFS_SVH
`define OCC_TRACK_DEFS_SVH

// The occupancy level needs 5 bits to reach 23
`define OCC_VALUE_W 5

// Width of a push or pop count
`define OCC_CHANGE_W 3

// The buffer holds at most 23 entries and the level never goes above that
`define OCC_MAX_VALUE 23

// A push or pop may move at most 6 entries and a count of 7 is illegal
`define OCC_MAX_CHANGE 6

// Width of the saturating dropped-event counter
`define OCC_DROP_W 8

`endif

// ==== source/occ_track_pkg.sv ====
// Occupancy tracker types
// Packed structs that carry one cycle of data between the pipeline stages

`include "occ_track_defs.svh"

package occ_track_pkg;

  // ------------------------------------------------------------
  // Stage 1 to stage 2
  // ------------------------------------------------------------

  // Qualified change for one cycle with all valid bits clear for a dropped event
  typedef struct packed {
    logic                     reinit;
    logic [`OCC_VALUE_W-1:0]  init_level;
    logic                     incr_valid;
    logic [`OCC_CHANGE_W-1:0] incr;
    logic                     decr_valid;
    logic [`OCC_CHANGE_W-1:0] decr;
  } occ_change_t;

  // ------------------------------------------------------------
  // Stage 2 to stage 3
  // ------------------------------------------------------------

  // Counter output where updated is high in the cycle after a change was taken
  typedef struct packed {
    logic [`OCC_VALUE_W-1:0] value;
    logic                    updated;
  } occ_level_t;

  // Buffer status as seen by the consumers
  typedef struct packed {
    logic [`OCC_VALUE_W-1:0] level;
    logic                    empty;
    logic                    full;
    logic                    almost_full;
  } occ_status_t;

endpackage

// ==== source/occ_event_decode.sv ====
// Occupancy event decoder, first pipeline stage
// Range-checks push, pop and flush strobes, registers the qualified change
// and keeps a saturating count of the events it had to drop

`timescale 1ns/100ps

`include "occ_track_defs.svh"

module occ_event_decode (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            push,
  input  logic [`OCC_CHANGE_W-1:0]        push_count,
  input  logic                            pop,
  input  logic [`OCC_CHANGE_W-1:0]        pop_count,
  input  logic                            flush,
  input  logic [`OCC_VALUE_W-1:0]         flush_level,
  output occ_track_pkg::occ_change_t      change,
  output logic                            dropped,
  output logic [`OCC_DROP_W-1:0]          drop_count
);

  logic illegal;

  // Any strobed field out of range poisons the whole event
  assign illegal = (push && (push_count > `OCC_MAX_CHANGE)) ||
                   (pop && (pop_count > `OCC_MAX_CHANGE)) ||
                   (flush && (flush_level > `OCC_MAX_VALUE));

  // ------------------------------------------------------------
  // Qualified change register
  // ------------------------------------------------------------

  // Payload fields are zeroed along with their valid bit so stage 2 never sees stale counts
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      change <= '0;
    end else begin
      change.reinit     <= flush && !illegal;
      change.init_level <= (flush && !illegal) ? flush_level : '0;
      change.incr_valid <= push && !illegal;
      change.incr       <= (push && !illegal) ? push_count : '0;
      change.decr_valid <= pop && !illegal;
      change.decr       <= (pop && !illegal) ? pop_count : '0;
    end
  end

  // ------------------------------------------------------------
  // Drop reporting
  // ------------------------------------------------------------

  // The count sticks at all ones rather than wrapping back to zero
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dropped    <= 1'b0;
      drop_count <= '0;
    end else begin
      dropped <= illegal;
      if (illegal && (drop_count != '1)) begin
        drop_count <= drop_count + 1'b1;
      end
    end
  end

  // Stage 2 relies on never receiving a count above the legal maximum
  change_in_range_a: assert property (@(posedge clk) disable iff (!arst_n)
    (change.incr <= `OCC_MAX_CHANGE) && (change.decr <= `OCC_MAX_CHANGE));

endmodule

// ==== source/occ_counter.sv ====
// Occupancy counter, second pipeline stage
// Increment/decrement counter over 0..23 that wraps modulo 24 with explicit
// correction, or clamps at both ends when saturate_en is set. A reinit
// loads init_level and applies the same cycle's change on top of it

`timescale 1ns/100ps

`include "occ_track_defs.svh"

module occ_counter #(
  parameter bit saturate_en = 1'b0
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  occ_track_pkg::occ_change_t change,
  output occ_track_pkg::occ_level_t  level
);

  // One extra bit so that a net decrement below zero shows up as a set MSB
  localparam int TEMP_W = `OCC_VALUE_W + 1;
  localparam logic [TEMP_W-1:0] MAX_VALUE_T = TEMP_W'(`OCC_MAX_VALUE);
  localparam logic [TEMP_W-1:0] MAX_VALUE_P1 = TEMP_W'(`OCC_MAX_VALUE + 1);

  logic [`OCC_CHANGE_W-1:0] incr_qual;
  logic [`OCC_CHANGE_W-1:0] decr_qual;
  logic [`OCC_VALUE_W-1:0]  base;
  logic [TEMP_W-1:0]        value_temp;
  logic [TEMP_W-1:0]        value_fixed;
  logic                     would_underflow;
  logic                     would_overflow;
  logic                     loaden;
  logic [`OCC_VALUE_W-1:0]  value_next;

  // ------------------------------------------------------------
  // Raw sum
  // ------------------------------------------------------------

  assign incr_qual = change.incr_valid ? change.incr : '0;
  assign decr_qual = change.decr_valid ? change.decr : '0;

  // On reinit the change lands on the flush level instead of the old value
  assign base = change.reinit ? change.init_level : level.value;

  assign value_temp = TEMP_W'(base) + TEMP_W'(incr_qual) - TEMP_W'(decr_qual);

  // Largest positive sum is 23 + 6, which never reaches the MSB
  assign would_underflow = value_temp[TEMP_W-1];
  assign would_overflow  = !value_temp[TEMP_W-1] && (value_temp > MAX_VALUE_T);

  // ------------------------------------------------------------
  // Wrap or clamp
  // ------------------------------------------------------------

  // 24 is not a power of two, so the modulo needs an explicit add or subtract
  always_comb begin
    value_fixed = value_temp;
    if (saturate_en) begin
      if (would_underflow) begin
        value_fixed = '0;
      end else if (would_overflow) begin
        value_fixed = MAX_VALUE_T;
      end
    end else begin
      if (would_underflow) begin
        value_fixed = value_temp + MAX_VALUE_P1;
      end else if (would_overflow) begin
        value_fixed = value_temp - MAX_VALUE_P1;
      end
    end
  end

  // After correction the top bit is always clear
  assign value_next = value_fixed[`OCC_VALUE_W-1:0];

  assign loaden = change.reinit || change.incr_valid || change.decr_valid;

  // ------------------------------------------------------------
  // Level register
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      level <= '0;
    end else begin
      level.updated <= loaden;
      if (loaden) begin
        level.value <= value_next;
      end
    end
  end

  value_in_range_a: assert property (@(posedge clk) disable iff (!arst_n)
    level.value <= `OCC_MAX_VALUE);

  // A load must land exactly the value that was computed one cycle earlier
  value_loaded_a: assert property (@(posedge clk) disable iff (!arst_n)
    loaden |=> level.updated && (level.value == $past(value_next)));

  // Stage 1 filters flush levels, so an out-of-range reinit means a broken decoder
  reinit_in_range_a: assert property (@(posedge clk) disable iff (!arst_n)
    change.reinit |-> (change.init_level <= `OCC_MAX_VALUE));

endmodule

// ==== source/occ_watermark.sv ====
// Occupancy watermark, third pipeline stage
// Derives empty, full and almost_full from the counter level, with
// hysteresis on almost_full between the low and the high mark

`timescale 1ns/100ps

`include "occ_track_defs.svh"

module occ_watermark (
  input  logic                        clk,
  input  logic                        arst_n,
  input  occ_track_pkg::occ_level_t   level,
  input  logic [`OCC_VALUE_W-1:0]     hi_mark,
  input  logic [`OCC_VALUE_W-1:0]     lo_mark,
  output occ_track_pkg::occ_status_t  status,
  output logic                        status_changed
);

  logic empty_next;
  logic full_next;
  logic almost_full_next;
  logic flags_differ;

  // ------------------------------------------------------------
  // Flag derivation
  // ------------------------------------------------------------

  assign empty_next = (level.value == '0);
  assign full_next  = (level.value == `OCC_MAX_VALUE);

  // Between the marks the flag keeps whatever it was, which gives the hysteresis
  always_comb begin
    almost_full_next = status.almost_full;
    if (level.value >= hi_mark) begin
      almost_full_next = 1'b1;
    end else if (level.value <= lo_mark) begin
      almost_full_next = 1'b0;
    end
  end

  assign flags_differ = (empty_next != status.empty) ||
                        (full_next != status.full) ||
                        (almost_full_next != status.almost_full);

  // ------------------------------------------------------------
  // Status register
  // ------------------------------------------------------------

  // The level only moves on an update, so the flags can only move then too
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      status             <= '0;
      status.empty       <= 1'b1;
      status_changed     <= 1'b0;
    end else begin
      status_changed <= level.updated && flags_differ;
      if (level.updated) begin
        status.level       <= level.value;
        status.empty       <= empty_next;
        status.full        <= full_next;
        status.almost_full <= almost_full_next;
      end
    end
  end

  // Marks that overlap would leave almost_full without a hold band
  marks_ordered_a: assert property (@(posedge clk) disable iff (!arst_n)
    lo_mark < hi_mark);

endmodule

// ==== source/occ_track_top.sv ====
// Occupancy tracker top level
// Chains event decode, counter and watermark stages. An event reaches
// level two cycles later and status three cycles later

`timescale 1ns/100ps

`include "occ_track_defs.svh"

module occ_track_top #(
  parameter bit saturate_en = 1'b0
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        push,
  input  logic [`OCC_CHANGE_W-1:0]    push_count,
  input  logic                        pop,
  input  logic [`OCC_CHANGE_W-1:0]    pop_count,
  input  logic                        flush,
  input  logic [`OCC_VALUE_W-1:0]     flush_level,
  input  logic [`OCC_VALUE_W-1:0]     hi_mark,
  input  logic [`OCC_VALUE_W-1:0]     lo_mark,
  output occ_track_pkg::occ_level_t   level,
  output occ_track_pkg::occ_status_t  status,
  output logic                        status_changed,
  output logic                        dropped,
  output logic [`OCC_DROP_W-1:0]      drop_count
);

  // Qualified change between stage 1 and stage 2
  occ_track_pkg::occ_change_t change;

  occ_event_decode u_decode (
    .clk         (clk),
    .arst_n      (arst_n),
    .push        (push),
    .push_count  (push_count),
    .pop         (pop),
    .pop_count   (pop_count),
    .flush       (flush),
    .flush_level (flush_level),
    .change      (change),
    .dropped     (dropped),
    .drop_count  (drop_count)
  );

  occ_counter #(
    .saturate_en (saturate_en)
  ) u_counter (
    .clk    (clk),
    .arst_n (arst_n),
    .change (change),
    .level  (level)
  );

  // The counter output feeds both the watermark stage and the top port
  occ_watermark u_watermark (
    .clk            (clk),
    .arst_n         (arst_n),
    .level          (level),
    .hi_mark        (hi_mark),
    .lo_mark        (lo_mark),
    .status         (status),
    .status_changed (status_changed)
  );

endmodule

// ==== include/occ_track_tb_vectors.svh ====
// Occupancy tracker directed vectors
// One row per event with its inputs and the level and flags expected
// after the event has passed through the pipeline (marks 18 and 12)

`ifndef OCC_TRACK_TB_VECTORS_SVH
`define OCC_TRACK_TB_VECTORS_SVH

localparam int NUM_ROWS = 35;

typedef struct packed {
  logic                     push;
  logic [`OCC_CHANGE_W-1:0] push_count;
  logic                     pop;
  logic [`OCC_CHANGE_W-1:0] pop_count;
  logic                     flush;
  logic [`OCC_VALUE_W-1:0]  flush_level;
  logic [`OCC_VALUE_W-1:0]  exp_value;
  logic                     exp_empty;
  logic                     exp_full;
  logic                     exp_af;
  logic                     exp_dropped;
} vector_row_t;

function automatic vector_row_t make_row(input int p, input int pc, input int po,
                                         input int poc, input int f, input int fl,
                                         input int v, input int e, input int fu,
                                         input int af, input int d);
  vector_row_t row;
  row = {p[0], pc[2:0], po[0], poc[2:0], f[0], fl[4:0], v[4:0], e[0], fu[0], af[0], d[0]};
  return row;
endfunction

// Columns are push, push_count, pop, pop_count, flush, flush_level,
// then expected value, empty, full, almost_full and dropped
function automatic vector_row_t get_row(input int idx);
  vector_row_t row;
  row = '0;
  case (idx)
    0:  row = make_row(1, 3, 0, 0, 0,  0,  3, 0, 0, 0, 0);
    1:  row = make_row(1, 6, 0, 0, 0,  0,  9, 0, 0, 0, 0);
    2:  row = make_row(0, 0, 1, 2, 0,  0,  7, 0, 0, 0, 0);
    3:  row = make_row(1, 5, 1, 1, 0,  0, 11, 0, 0, 0, 0);
    4:  row = make_row(1, 4, 1, 4, 0,  0, 11, 0, 0, 0, 0);
    5:  row = make_row(1, 6, 0, 0, 0,  0, 17, 0, 0, 0, 0);
    // Climb to the high mark, then walk down through the hold band
    6:  row = make_row(1, 1, 0, 0, 0,  0, 18, 0, 0, 1, 0);
    7:  row = make_row(0, 0, 1, 3, 0,  0, 15, 0, 0, 1, 0);
    8:  row = make_row(0, 0, 1, 2, 0,  0, 13, 0, 0, 1, 0);
    9:  row = make_row(0, 0, 1, 1, 0,  0, 12, 0, 0, 0, 0);
    10: row = make_row(1, 5, 0, 0, 0,  0, 17, 0, 0, 0, 0);
    11: row = make_row(1, 5, 0, 0, 0,  0, 22, 0, 0, 1, 0);
    12: row = make_row(0, 0, 0, 0, 0,  0, 22, 0, 0, 1, 0);
    // Wrap upward 22 + 5 and downward 1 - 4
    13: row = make_row(1, 5, 0, 0, 0,  0,  3, 0, 0, 0, 0);
    14: row = make_row(0, 0, 1, 2, 0,  0,  1, 0, 0, 0, 0);
    15: row = make_row(0, 0, 1, 4, 0,  0, 21, 0, 0, 1, 0);
    16: row = make_row(1, 2, 0, 0, 0,  0, 23, 0, 1, 1, 0);
    // Illegal counts and an illegal flush level leave the level alone
    17: row = make_row(1, 7, 0, 0, 0,  0, 23, 0, 1, 1, 1);
    18: row = make_row(1, 1, 1, 7, 0,  0, 23, 0, 1, 1, 1);
    19: row = make_row(0, 0, 0, 0, 1, 25, 23, 0, 1, 1, 1);
    20: row = make_row(0, 0, 0, 0, 1,  5,  5, 0, 0, 0, 0);
    21: row = make_row(1, 4, 0, 0, 1, 10, 14, 0, 0, 0, 0);
    22: row = make_row(0, 0, 1, 3, 1, 20, 17, 0, 0, 0, 0);
    23: row = make_row(0, 0, 0, 0, 1,  0,  0, 1, 0, 0, 0);
    24: row = make_row(0, 0, 0, 0, 0,  0,  0, 1, 0, 0, 0);
    25: row = make_row(0, 0, 1, 1, 0,  0, 23, 0, 1, 1, 0);
    26: row = make_row(1, 1, 0, 0, 0,  0,  0, 1, 0, 0, 0);
    27: row = make_row(1, 6, 1, 2, 1, 23,  3, 0, 0, 0, 0);
    28: row = make_row(1, 1, 0, 0, 1, 24,  3, 0, 0, 0, 1);
    29: row = make_row(1, 6, 1, 6, 1, 18, 18, 0, 0, 1, 0);
    30: row = make_row(0, 0, 1, 7, 0,  0, 18, 0, 0, 1, 1);
    31: row = make_row(0, 0, 1, 6, 0,  0, 12, 0, 0, 0, 0);
    // A zero push still updates, and an unstrobed count of 7 is ignored
    32: row = make_row(1, 0, 0, 0, 0,  0, 12, 0, 0, 0, 0);
    33: row = make_row(0, 7, 0, 0, 0,  0, 12, 0, 0, 0, 0);
    34: row = make_row(0, 0, 0, 0, 1, 12, 12, 0, 0, 0, 0);
    default: row = '0;
  endcase
  return row;
endfunction

`endif

// ==== dv/occ_track_tb.sv ====
// Occupancy tracker testbench
// Applies a directed event table and a random phase to the full pipeline
// and checks level, status and drop reporting every cycle

`timescale 1ns/100ps

`include "occ_track_defs.svh"

module occ_track_tb;

  localparam int RANDOM_EVENTS = 200;
  localparam int DEPTH = `OCC_MAX_VALUE + 1;
  localparam int HI_MARK = 18;
  localparam int LO_MARK = 12;

  `include "occ_track_tb_vectors.svh"

  localparam int TIMEOUT_CYCLES = (NUM_ROWS + RANDOM_EVENTS + 20) * 2;

  // Everything expected from one event once it has crossed the pipeline
  typedef struct packed {
    occ_track_pkg::occ_level_t  level;
    occ_track_pkg::occ_status_t status;
    logic                       status_changed;
    logic                       dropped;
    logic [`OCC_DROP_W-1:0]     drop_count;
  } expect_t;

  logic                       clk = 1'b0;
  logic                       arst_n;
  logic                       push;
  logic [`OCC_CHANGE_W-1:0]   push_count;
  logic                       pop;
  logic [`OCC_CHANGE_W-1:0]   pop_count;
  logic                       flush;
  logic [`OCC_VALUE_W-1:0]    flush_level;
  logic [`OCC_VALUE_W-1:0]    hi_mark;
  logic [`OCC_VALUE_W-1:0]    lo_mark;
  occ_track_pkg::occ_level_t  level;
  occ_track_pkg::occ_status_t status;
  logic                       status_changed;
  logic                       dropped;
  logic [`OCC_DROP_W-1:0]     drop_count;

  // Expectation history indexed by event, read back at fixed pipeline depths
  expect_t                    hist [NUM_ROWS + RANDOM_EVENTS + 8];
  occ_track_pkg::occ_status_t prev_status;
  logic [`OCC_DROP_W-1:0]     exp_drop_count;
  int                         drive_idx;
  int                         model_value;
  logic                       model_af;
  int                         level_errors;
  int                         status_errors;
  int                         drop_errors;
  int                         cycle_count = 0;
  int unsigned                seed_ret;

  occ_track_top #(
    .saturate_en (1'b0)
  ) u_dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .push           (push),
    .push_count     (push_count),
    .pop            (pop),
    .pop_count      (pop_count),
    .flush          (flush),
    .flush_level    (flush_level),
    .hi_mark        (hi_mark),
    .lo_mark        (lo_mark),
    .level          (level),
    .status         (status),
    .status_changed (status_changed),
    .dropped        (dropped),
    .drop_count     (drop_count)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles before all events were checked", cycle_count);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------

  task automatic check_level(input occ_track_pkg::occ_level_t got,
                             input occ_track_pkg::occ_level_t exp, input int idx);
    if (got !== exp) begin
      level_errors++;
      $display("FAIL %0t: event %0d level %0d updated %0b, expected %0d updated %0b",
               $time, idx, got.value, got.updated, exp.value, exp.updated);
    end
  endtask

  task automatic check_status(input occ_track_pkg::occ_status_t got,
                              input occ_track_pkg::occ_status_t exp,
                              input logic got_changed, input logic exp_changed, input int idx);
    if ((got !== exp) || (got_changed !== exp_changed)) begin
      status_errors++;
      $display("FAIL %0t: event %0d status lvl %0d e%0b f%0b af%0b chg %0b, %s",
               $time, idx, got.level, got.empty, got.full, got.almost_full, got_changed,
               $sformatf("expected %0d e%0b f%0b af%0b chg %0b", exp.level, exp.empty,
                         exp.full, exp.almost_full, exp_changed));
    end
  endtask

  task automatic check_drop(input logic got_dropped, input logic [`OCC_DROP_W-1:0] got_count,
                            input logic exp_dropped, input logic [`OCC_DROP_W-1:0] exp_count,
                            input int idx);
    if ((got_dropped !== exp_dropped) || (got_count !== exp_count)) begin
      drop_errors++;
      $display("FAIL %0t: event %0d dropped %0b count %0d, expected %0b count %0d",
               $time, idx, got_dropped, got_count, exp_dropped, exp_count);
    end
  endtask

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  function automatic logic model_illegal(input logic p, input int pc, input logic po,
                                         input int poc, input logic f, input int fl);
    return (p && (pc > `OCC_MAX_CHANGE)) || (po && (poc > `OCC_MAX_CHANGE)) ||
           (f && (fl > `OCC_MAX_VALUE));
  endfunction

  // A flush replaces the old level as the base, then the counts apply modulo the depth
  function automatic int model_next_level(input int cur, input logic p, input int pc,
                                          input logic po, input int poc,
                                          input logic f, input int fl);
    int sum;
    sum = (f ? fl : cur) + (p ? pc : 0) - (po ? poc : 0);
    return ((sum % DEPTH) + DEPTH) % DEPTH;
  endfunction

  // ------------------------------------------------------------
  // Event driver
  // ------------------------------------------------------------

  // Records what one event should produce, drives it and checks older events.
  // An event driven at edge p shows on dropped after p+1, on level after p+2
  // and on status after p+3
  task automatic apply_event(input logic p, input int pc, input logic po, input int poc,
                             input logic f, input int fl, input int value, input logic empty,
                             input logic full, input logic af, input logic drop);
    expect_t e;
    e.level.value        = value[`OCC_VALUE_W-1:0];
    e.level.updated      = (p || po || f) && !drop;
    e.status.level       = value[`OCC_VALUE_W-1:0];
    e.status.empty       = empty;
    e.status.full        = full;
    e.status.almost_full = af;
    e.status_changed     = {empty, full, af} !=
                           {prev_status.empty, prev_status.full, prev_status.almost_full};
    if (drop && (exp_drop_count != '1)) begin
      exp_drop_count = exp_drop_count + 1'b1;
    end
    e.dropped         = drop;
    e.drop_count      = exp_drop_count;
    hist[drive_idx]   = e;
    prev_status       = e.status;
    @(posedge clk);
    push        <= p;
    push_count  <= pc[`OCC_CHANGE_W-1:0];
    pop         <= po;
    pop_count   <= poc[`OCC_CHANGE_W-1:0];
    flush       <= f;
    flush_level <= fl[`OCC_VALUE_W-1:0];
    @(negedge clk);
    if (drive_idx >= 1) begin
      check_drop(dropped, drop_count, hist[drive_idx-1].dropped,
                 hist[drive_idx-1].drop_count, drive_idx - 1);
    end
    if (drive_idx >= 2) begin
      check_level(level, hist[drive_idx-2].level, drive_idx - 2);
    end
    if (drive_idx >= 3) begin
      check_status(status, hist[drive_idx-3].status, status_changed,
                   hist[drive_idx-3].status_changed, drive_idx - 3);
    end
    drive_idx++;
  endtask

  task automatic run_table();
    vector_row_t row;
    for (int r = 0; r < NUM_ROWS; r++) begin
      row = get_row(r);
      apply_event(row.push, row.push_count, row.pop, row.pop_count, row.flush,
                  row.flush_level, row.exp_value, row.exp_empty, row.exp_full,
                  row.exp_af, row.exp_dropped);
      // The random phase continues from the level the table ends on
      model_value = row.exp_value;
      model_af    = row.exp_af;
    end
  endtask

  // One event every cycle keeps three events in flight across the stages
  task automatic run_random();
    logic p;
    logic po;
    logic f;
    logic drop;
    int   pc;
    int   poc;
    int   fl;
    for (int i = 0; i < RANDOM_EVENTS; i++) begin
      p    = ($urandom % 4) != 0;
      pc   = $urandom % 8;
      po   = ($urandom % 2) != 0;
      poc  = $urandom % 8;
      f    = ($urandom % 10) == 0;
      fl   = $urandom % 32;
      drop = model_illegal(p, pc, po, poc, f, fl);
      if (!drop && (p || po || f)) begin
        model_value = model_next_level(model_value, p, pc, po, poc, f, fl);
        if (model_value >= HI_MARK) begin
          model_af = 1'b1;
        end else if (model_value <= LO_MARK) begin
          model_af = 1'b0;
        end
      end
      apply_event(p, pc, po, poc, f, fl, model_value, model_value == 0,
                  model_value == `OCC_MAX_VALUE, model_af, drop);
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    seed_ret       = $urandom(32'ha0d7a927);
    arst_n         = 1'b0;
    push           = 1'b0;
    push_count     = '0;
    pop            = 1'b0;
    pop_count      = '0;
    flush          = 1'b0;
    flush_level    = '0;
    hi_mark        = HI_MARK;
    lo_mark        = LO_MARK;
    drive_idx      = 0;
    model_value    = 0;
    model_af       = 1'b0;
    exp_drop_count = '0;
    level_errors   = 0;
    status_errors  = 0;
    drop_errors    = 0;
    prev_status       = '0;
    prev_status.empty = 1'b1;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    // Reset leaves an empty buffer with nothing pending
    @(negedge clk);
    check_level(level, '0, -1);
    check_status(status, prev_status, status_changed, 1'b0, -1);
    check_drop(dropped, drop_count, 1'b0, '0, -1);
    run_table();
    run_random();
    // Idle events drain the last real events out of the pipeline
    repeat (4) begin
      apply_event(1'b0, 0, 1'b0, 0, 1'b0, 0, model_value, model_value == 0,
                  model_value == `OCC_MAX_VALUE, model_af, 1'b0);
    end
    $display("Errors: level %0d, status %0d, drop %0d", level_errors, status_errors,
             drop_errors);
    if ((level_errors + status_errors + drop_errors) == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== occ_track.f ====
+incdir+include
source/occ_track_pkg.sv
source/occ_event_decode.sv
source/occ_counter.sv
source/occ_watermark.sv
source/occ_track_top.sv
dv/occ_track_tb.sv

// ==== Bender.yml ====
package:
  name: occ_track

export_include_dirs:
  - include

sources:
  - source/occ_track_pkg.sv
  - source/occ_event_decode.sv
  - source/occ_counter.sv
  - source/occ_watermark.sv
  - source/occ_track_top.sv
  - target: test
    files:
      - dv/occ_track_tb.sv
